//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // rv32i major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b  // lui
    } alu_op_e;

    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sub  = 3'b000;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_addi = 3'b000;
    localparam logic [2:0] f3_lw   = 3'b010;
    localparam logic [2:0] f3_sw   = 3'b010;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    localparam logic [6:0] f7_add = 7'b0000000;
    localparam logic [6:0] f7_sub = 7'b0100000;
    localparam logic [6:0] f7_and = 7'b0000000;
    localparam logic [6:0] f7_or  = 7'b0000000;
    localparam logic [6:0] f7_xor = 7'b0000000;

    localparam logic [31:0] nop_instr = 32'h0000_0013;  // addi x0,x0,0

endpackage

//--- hdl/core_pkg.sv
package core_pkg;

    import rv_isa_pkg::*;

    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    // code below, data at or above
    localparam logic [xlen-1:0] data_base = 32'h0000_0400;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [31:0]     instr;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pc4;
        logic [xlen-1:0] data1;
        logic [xlen-1:0] data2;
        logic [xlen-1:0] imm;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        opcode_e         opcode;
        alu_op_e         alu_op;
        logic [2:0]      funct3;
        logic            wr_reg_n;  // active low
        logic            flush;     // entry is a bubble
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] wdata;
        logic            wr_reg_n;
    } ex_wb_t;

    typedef struct packed {
        logic        valid;
        logic        we;
        logic [9:0]  addr;  // word address
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [4:0]      rd;
        logic [xlen-1:0] wdata;
        logic            wr;
    } retire_t;

endpackage

//--- hdl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit import core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        interlock,
    input  logic        redirect_valid,
    input  logic [31:0] redirect_pc,
    input  logic        gnt,
    input  mem_rsp_t    rsp,
    output mem_req_t    req,
    output if_id_t      if_id
);

    logic [xlen-1:0] pc;
    logic            if_valid;
    logic            from_mem;  // instr arrives on rsp this cycle
    logic [xlen-1:0] if_pc;
    logic [31:0]     instr_q;
    logic            hold;
    logic            started;   // low until the first cycle out of reset

    assign hold = stall || interlock;

    always_comb begin
        req       = '0;
        req.valid = started && !hold && !redirect_valid;
        req.addr  = pc[11:2];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            started <= 1'b0;
        else
            started <= 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            if_valid <= 1'b0;
            from_mem <= 1'b0;
        end else if (redirect_valid) begin
            pc       <= redirect_pc;  // nothing in flight, request was held back
            if_valid <= 1'b0;
            from_mem <= 1'b0;
        end else if (hold) begin
            from_mem <= 1'b0;
        end else begin
            if_valid <= gnt;  // denied fetch leaves a bubble
            from_mem <= gnt;
            if (gnt)
                pc <= pc + 32'd4;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (!redirect_valid && hold && from_mem)
            instr_q <= rsp.rdata;  // park the word while decode holds
        if (!redirect_valid && !hold && gnt)
            if_pc <= pc;
    end

    always_comb begin
        if_id.valid = if_valid;
        if_id.pc    = if_pc;
        if_id.instr = from_mem ? rsp.rdata : instr_q;
    end

endmodule

//--- hdl/decode_unit.sv
`timescale 1ns/10ps

module decode_unit import rv_isa_pkg::*, core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  if_id_t if_id,
    input  id_ex_t ex_entry,
    input  ex_wb_t wb,
    output id_ex_t id_ex,
    output logic   interlock
);

    logic [xlen-1:0] rf [1:31];
    logic [31:0]     instr;
    logic [4:0]      rs1, rs2, rd;
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    opcode_e         opc;
    logic            known, writes, uses_rs1, uses_rs2;
    logic            hit1, hit2, ex_live_wr;
    logic [4:0]      ld_rd_q;  // rd of a load waiting for its data
    logic [xlen-1:0] data1, data2, imm;

    assign instr  = if_id.valid ? if_id.instr : nop_instr;
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign opc    = opcode_e'(instr[6:0]);

    always_comb begin
        known    = 1'b1;
        writes   = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        imm      = {{20{instr[31]}}, instr[31:20]};  // i-type
        case (opc)
            opc_op:     begin writes = 1'b1; uses_rs1 = 1'b1; uses_rs2 = 1'b1; end
            opc_op_imm: begin writes = 1'b1; uses_rs1 = 1'b1; end
            opc_load:   begin writes = 1'b1; uses_rs1 = 1'b1; end
            opc_lui: begin
                writes = 1'b1;
                imm    = {instr[31:12], 12'b0};
            end
            opc_store: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            opc_branch: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            opc_jal: begin
                writes = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: known = 1'b0;
        endcase
    end

    // register file, written from the result register, read with write-through
    always_ff @(posedge clk) begin
        if (wb.valid && !wb.wr_reg_n && wb.rd != 5'd0)
            rf[wb.rd] <= wb.wdata;
    end

    always_comb begin
        if (rs1 == 5'd0)
            data1 = '0;
        else if (wb.valid && !wb.wr_reg_n && wb.rd == rs1)
            data1 = wb.wdata;
        else
            data1 = rf[rs1];
        if (rs2 == 5'd0)
            data2 = '0;
        else if (wb.valid && !wb.wr_reg_n && wb.rd == rs2)
            data2 = wb.wdata;
        else
            data2 = rf[rs2];
    end

    assign ex_live_wr = !ex_entry.flush && !ex_entry.wr_reg_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ld_rd_q <= 5'd0;
        else if (ex_live_wr && ex_entry.opcode == opc_load)
            ld_rd_q <= ex_entry.rd;
        else
            ld_rd_q <= 5'd0;
    end

    assign hit1 = uses_rs1 && rs1 != 5'd0 &&
                  ((ex_live_wr && ex_entry.rd == rs1) || ld_rd_q == rs1);
    assign hit2 = uses_rs2 && rs2 != 5'd0 &&
                  ((ex_live_wr && ex_entry.rd == rs2) || ld_rd_q == rs2);
    assign interlock = if_id.valid && (hit1 || hit2);

    always_comb begin
        id_ex.pc       = if_id.pc;
        id_ex.pc4      = if_id.pc + 32'd4;
        id_ex.data1    = data1;
        id_ex.data2    = data2;
        id_ex.imm      = imm;
        id_ex.rs2      = rs2;
        id_ex.rd       = rd;
        id_ex.opcode   = opc;
        id_ex.funct3   = funct3;
        id_ex.flush    = !if_id.valid || !known;  // unsupported becomes a bubble
        id_ex.wr_reg_n = id_ex.flush || !writes || rd == 5'd0;
        case (opc)
            opc_op: begin
                if (funct7 == f7_sub && funct3 == f3_sub)
                    id_ex.alu_op = alu_sub;
                else if (funct7 == f7_xor && funct3 == f3_xor)
                    id_ex.alu_op = alu_xor;
                else if (funct7 == f7_or && funct3 == f3_or)
                    id_ex.alu_op = alu_or;
                else if (funct7 == f7_and && funct3 == f3_and)
                    id_ex.alu_op = alu_and;
                else
                    id_ex.alu_op = alu_add;
            end
            opc_lui:    id_ex.alu_op = alu_pass_b;
            opc_branch: id_ex.alu_op = alu_sub;
            default:    id_ex.alu_op = alu_add;  // addi, address and link
        endcase
    end

    a_known_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        (if_id.valid && !interlock && !id_ex.flush) |->
        id_ex.opcode inside {opc_op, opc_op_imm, opc_lui, opc_load, opc_store,
                             opc_branch, opc_jal});

endmodule

//--- hdl/id_ex_regs.sv
`timescale 1ns/10ps

module id_ex_regs import core_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall,
    input  logic   interlock,
    input  logic   redirect_valid,
    input  id_ex_t d,
    output id_ex_t q
);

    logic hold;

    assign hold = stall || interlock;  // interlock acts just like stall

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q          <= '0;
            q.wr_reg_n <= 1'b1;  // no write out of reset
        end else if (redirect_valid) begin
            q          <= d;  // younger instruction, squashed
            q.wr_reg_n <= 1'b1;
            q.flush    <= 1'b1;
        end else if (hold) begin
            // keep contents but never let the held copy commit again
            q.wr_reg_n <= 1'b1;
            q.flush    <= 1'b1;
        end else begin
            q <= d;
        end
    end

    a_hold_kills_write: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> q.wr_reg_n);

endmodule

//--- hdl/execute_unit.sv
`timescale 1ns/10ps

module execute_unit import rv_isa_pkg::*, core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  id_ex_t      e,
    input  logic        gnt,
    input  mem_rsp_t    rsp,
    output mem_req_t    req,
    output logic        stall,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output ex_wb_t      wb,
    output retire_t     retire
);

    typedef enum logic {st_idle, st_load_wait} ex_state_e;

    ex_state_e       state, state_d;
    logic [xlen-1:0] op_b, alu_y;
    logic            taken;
    ex_wb_t          wb_d;
    logic [xlen-1:0] ld_pc;
    logic [4:0]      ld_rd;
    logic            ld_wr_n;

    assign op_b = (e.opcode == opc_op) ? e.data2 : e.imm;

    always_comb begin
        case (e.alu_op)
            alu_sub:    alu_y = e.data1 - op_b;
            alu_and:    alu_y = e.data1 & op_b;
            alu_or:     alu_y = e.data1 | op_b;
            alu_xor:    alu_y = e.data1 ^ op_b;
            alu_pass_b: alu_y = op_b;
            default:    alu_y = e.data1 + op_b;
        endcase
    end

    // beq or bne
    assign taken = (e.funct3 == f3_bne) ? (e.data1 != e.data2) : (e.data1 == e.data2);
    assign redirect_pc = e.pc + e.imm;

    always_comb begin
        wb_d           = '0;
        wb_d.wr_reg_n  = 1'b1;
        wb_d.pc        = e.pc;
        wb_d.rd        = e.rd;
        req            = '0;
        redirect_valid = 1'b0;
        state_d        = state;
        if (state == st_load_wait) begin
            wb_d.valid    = 1'b1;  // load data is back
            wb_d.pc       = ld_pc;
            wb_d.rd       = ld_rd;
            wb_d.wdata    = rsp.rdata;
            wb_d.wr_reg_n = ld_wr_n;
            state_d       = st_idle;
        end else if (!e.flush) begin
            case (e.opcode)
                opc_op, opc_op_imm, opc_lui: begin
                    wb_d.valid    = 1'b1;
                    wb_d.wdata    = alu_y;
                    wb_d.wr_reg_n = e.wr_reg_n;
                end
                opc_jal: begin
                    wb_d.valid     = 1'b1;
                    wb_d.wdata     = e.pc4;  // link
                    wb_d.wr_reg_n  = e.wr_reg_n;
                    redirect_valid = 1'b1;
                end
                opc_branch: begin
                    wb_d.valid     = 1'b1;
                    redirect_valid = taken;
                end
                opc_store: begin
                    req.valid  = 1'b1;
                    req.we     = 1'b1;
                    req.addr   = alu_y[11:2];
                    req.wdata  = e.data2;
                    wb_d.valid = gnt;
                end
                opc_load: begin
                    req.valid = 1'b1;
                    req.addr  = alu_y[11:2];
                    if (gnt)
                        state_d = st_load_wait;
                end
                default: ;
            endcase
        end
    end

    assign stall = (state == st_idle && !e.flush && e.opcode == opc_load) ||
                   (req.valid && !gnt);

    // load context, the held entry is flushed while the data returns
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            ld_pc   <= e.pc;
            ld_rd   <= e.rd;
            ld_wr_n <= e.wr_reg_n;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= st_idle;
            wb          <= '0;
            wb.wr_reg_n <= 1'b1;
            retire      <= '0;
        end else begin
            state        <= state_d;
            wb           <= wb_d;
            retire.valid <= wb_d.valid;
            retire.pc    <= wb_d.pc;
            retire.rd    <= wb_d.rd;
            retire.wdata <= wb_d.wdata;
            retire.wr    <= !wb_d.wr_reg_n;  // active high at the port
        end
    end

    a_stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        not (stall [*3]));

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t fetch_req,
    input  mem_req_t data_req,
    output logic     fetch_gnt,
    output logic     data_gnt,
    output mem_req_t mem_req
);

    logic last_data_rd;  // data read granted last cycle, response owned by execute

    // fixed priority, data first
    assign data_gnt  = data_req.valid;
    assign fetch_gnt = fetch_req.valid && !data_req.valid;

    always_comb begin
        if (data_gnt)
            mem_req = data_req;
        else
            mem_req = fetch_req;  // valid low when nobody asks
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            last_data_rd <= 1'b0;
        else
            last_data_rd <= data_gnt && !data_req.we;
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(fetch_gnt && data_gnt));

    // a load is not re-issued while its response is on the bus
    a_load_rsp_owner: assert property (@(posedge clk) disable iff (!rst_n)
        last_data_rd |-> !(data_gnt && !data_req.we));

endmodule

//--- hdl/core_top.sv
`timescale 1ns/10ps

module core_top import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_rsp_t mem_rsp,
    output mem_req_t mem_req,
    output retire_t  retire
);

    mem_req_t    fetch_req, data_req;
    logic        fetch_gnt, data_gnt;
    logic        stall, interlock, redirect_valid;
    logic [31:0] redirect_pc;
    if_id_t      if_id;
    id_ex_t      id_ex_d, id_ex_q;
    ex_wb_t      wb;

    fetch_unit fetch_unit_i (
        .clk(clk), .rst_n(rst_n), .stall(stall), .interlock(interlock),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .gnt(fetch_gnt), .rsp(mem_rsp), .req(fetch_req), .if_id(if_id)
    );

    decode_unit decode_unit_i (
        .clk(clk), .rst_n(rst_n), .if_id(if_id), .ex_entry(id_ex_q), .wb(wb),
        .id_ex(id_ex_d), .interlock(interlock)
    );

    id_ex_regs id_ex_regs_i (
        .clk(clk), .rst_n(rst_n), .stall(stall), .interlock(interlock),
        .redirect_valid(redirect_valid), .d(id_ex_d), .q(id_ex_q)
    );

    execute_unit execute_unit_i (
        .clk(clk), .rst_n(rst_n), .e(id_ex_q), .gnt(data_gnt), .rsp(mem_rsp),
        .req(data_req), .stall(stall), .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc), .wb(wb), .retire(retire)
    );

    mem_arbiter mem_arbiter_i (
        .clk(clk), .rst_n(rst_n), .fetch_req(fetch_req), .data_req(data_req),
        .fetch_gnt(fetch_gnt), .data_gnt(data_gnt), .mem_req(mem_req)
    );

endmodule

//--- bench/tb_iss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// one committed instruction as the reference model sees it
typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        wr;
    logic        is_load;
    logic        is_store;
    logic        jumped;   // taken branch or jal
    logic [31:0] st_addr;
    logic [31:0] st_data;
    logic        bad;      // opcode outside the subset
} iss_step_t;

logic [31:0] iss_regs [0:31];
logic [31:0] iss_mem [0:1023];
logic [31:0] iss_pc;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// executes the instruction at iss_pc and advances the model state
function automatic iss_step_t iss_step();
    iss_step_t   s;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] nxt;
    logic        writes;
    ins    = iss_mem[iss_pc[11:2]];
    a      = iss_regs[ins[19:15]];
    b      = iss_regs[ins[24:20]];
    imm_i  = {{20{ins[31]}}, ins[31:20]};
    s      = '0;
    s.pc   = iss_pc;
    s.rd   = ins[11:7];
    nxt    = iss_pc + 32'd4;
    writes = 1'b1;
    case (ins[6:0])
        7'h33: begin
            case ({ins[30], ins[14:12]})
                4'b0000: s.wdata = a + b;
                4'b1000: s.wdata = a - b;
                4'b0111: s.wdata = a & b;
                4'b0110: s.wdata = a | b;
                4'b0100: s.wdata = a ^ b;
                default: s.bad = 1'b1;
            endcase
        end
        7'h13: s.wdata = a + imm_i;  // addi only
        7'h37: s.wdata = {ins[31:12], 12'h000};
        7'h03: begin
            addr      = a + imm_i;
            s.wdata   = iss_mem[addr[11:2]];
            s.is_load = 1'b1;
        end
        7'h23: begin
            addr                 = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
            iss_mem[addr[11:2]]  = b;
            s.is_store           = 1'b1;
            s.st_addr            = addr;
            s.st_data            = b;
            writes               = 1'b0;
        end
        7'h63: begin
            writes = 1'b0;
            if (ins[12] ? (a != b) : (a == b)) begin  // bne or beq
                nxt      = iss_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                     ins[11:8], 1'b0};
                s.jumped = 1'b1;
            end
        end
        7'h6f: begin
            s.wdata  = iss_pc + 32'd4;
            nxt      = iss_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            s.jumped = 1'b1;
        end
        default: begin
            s.bad  = 1'b1;
            writes = 1'b0;
        end
    endcase
    s.wr = writes && s.rd != 5'd0;
    if (s.wr)
        iss_regs[s.rd] = s.wdata;
    iss_pc = nxt;
    return s;
endfunction

`endif

//--- bench/core_tb.sv
`timescale 1ns/10ps

module core_tb import core_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst_n;
    mem_rsp_t    mem_rsp;
    mem_req_t    mem_req;
    retire_t     retire;

    logic [31:0] mem [0:1023];
    mem_req_t    req_q;           // request seen in the current cycle
    logic [9:0]  wr_addr_q [$];   // writes seen on the bus, not yet retired
    logic [31:0] wr_data_q [$];
    logic [31:0] rng;
    logic [31:0] final_pc;
    logic        seen_first_req = 1'b0;
    int          prog_len;
    int          cycles = 0;
    int          cycle_limit;
    int          loop_retires = 0;
    int          both_req = 0;
    int          loads_seen = 0;
    int          stores_seen = 0;
    int          jumps_seen = 0;

    `include "tb_iss.svh"

    core_top core_top_i (
        .clk(clk), .rst_n(rst_n), .mem_rsp(mem_rsp), .mem_req(mem_req), .retire(retire)
    );

    initial forever #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic flag_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                            $time, name, got, want));
    endtask

    function automatic logic [31:0] rand_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [4:0] pick_rd();
        logic [31:0] r;
        r = rand_word();
        return 5'd2 + 5'(r % 32'd11);  // x2..x12, x1 keeps data_base
    endfunction

    function automatic logic [4:0] pick_rs();
        logic [31:0] r;
        r = rand_word();
        return 5'(r % 32'd13);
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic bne);
        return {off[12], off[10:5], rs2, rs1, 2'b00, bne, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_alu(input logic [4:0] rd, input logic [4:0] ra, input logic [4:0] rb);
        logic [31:0] r;
        r = rand_word();
        case (r[2:0])
            3'd0:    emit({7'h00, rb, ra, 3'b000, rd, 7'h33});  // add
            3'd1:    emit({7'h20, rb, ra, 3'b000, rd, 7'h33});  // sub
            3'd2:    emit({7'h00, rb, ra, 3'b111, rd, 7'h33});  // and
            3'd3:    emit({7'h00, rb, ra, 3'b110, rd, 7'h33});  // or
            3'd4:    emit({7'h00, rb, ra, 3'b100, rd, 7'h33});  // xor
            default: emit(enc_i(r[31:20], ra, 3'b000, rd, 7'h13));
        endcase
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [11:0] off;
        int          skip;
        prog_len = 0;
        rng      = 32'h92c7;
        for (int a = 0; a < 1024; a++)
            mem[a] = {6'h2b, 10'(a), 6'h15, 10'(a)};
        emit(enc_i(12'h400, 5'd0, 3'b000, 5'd1, 7'h13));  // x1 = data_base
        for (int i = 2; i <= 12; i++) begin
            r = rand_word();
            emit({r[31:12], 5'(i), 7'h37});
            emit(enc_i(r[11:0], 5'(i), 3'b000, 5'(i), 7'h13));
        end
        for (int blk = 0; blk < 40; blk++) begin
            r    = rand_word();
            rd   = pick_rd();
            ra   = pick_rs();
            rb   = r[3] ? ra : pick_rs();  // equal operands, beq taken
            skip = r[4] ? 2 : 1;
            off  = {6'd0, r[11:8], 2'b00};
            case (r[2:0])
                3'd0, 3'd1: begin  // dependent pair
                    emit_alu(rd, ra, rb);
                    emit_alu(pick_rd(), rd, pick_rs());
                end
                3'd2: begin  // store then read back
                    emit(enc_s(off, rb, 5'd1));
                    emit(enc_i(off, 5'd1, 3'b010, rd, 7'h03));
                end
                3'd3: begin  // load-use
                    emit(enc_i(off, 5'd1, 3'b010, rd, 7'h03));
                    emit_alu(pick_rd(), rd, rd);
                end
                3'd4: begin
                    emit(enc_b(13'(4 * (skip + 1)), rb, ra, r[5]));
                    for (int k = 0; k < skip; k++)
                        emit_alu(pick_rd(), pick_rs(), pick_rs());
                end
                3'd5: begin
                    emit(enc_j(21'(4 * (skip + 1)), r[6] ? 5'd0 : rd));
                    for (int k = 0; k < skip; k++)
                        emit_alu(pick_rd(), pick_rs(), pick_rs());
                end
                3'd6: begin
                    emit({r[31:12], rd, 7'h37});
                    emit_alu(pick_rd(), rd, ra);
                end
                default: emit_alu(rd, ra, rb);
            endcase
        end
        final_pc = 32'(prog_len * 4);
        emit(enc_j(21'd0, 5'd0));  // self-loop
    endtask

    // memory answers one cycle after the request
    always @(posedge clk) begin
        #1;
        if (req_q.valid) begin
            if (req_q.we)
                mem[req_q.addr] = req_q.wdata;
            else
                mem_rsp.rdata = mem[req_q.addr];
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (cycles > cycle_limit)
                abort_run($sformatf("timeout: self-loop not reached after %0d cycles", cycles));
        end
    end

    always @(negedge clk) begin : check_cycle
        iss_step_t   want;
        logic [9:0]  wa;
        logic [31:0] wd;
        req_q = mem_req;
        if (!rst_n) begin
            assert (!retire.valid) else abort_run("retire valid while in reset");
            assert (!mem_req.valid) else abort_run("memory request while in reset");
        end else begin
            if (!seen_first_req && mem_req.valid) begin
                seen_first_req = 1'b1;
                assert (mem_req.addr == reset_pc[11:2])
                    else flag_mismatch("mem_req.addr", {22'd0, mem_req.addr},
                                       {22'd0, reset_pc[11:2]});
                assert (!mem_req.we) else abort_run("first request after reset is a write");
            end
            if (core_top_i.data_req.valid && core_top_i.fetch_req.valid) begin
                both_req++;
                assert (mem_req == core_top_i.data_req)
                    else abort_run("fetch won the memory port over a data request");
            end
            if (mem_req.valid && mem_req.we) begin
                wr_addr_q.push_back(mem_req.addr);
                wr_data_q.push_back(mem_req.wdata);
            end
            if (retire.valid) begin
                want = iss_step();
                assert (!want.bad) else abort_run("reference model hit an unsupported opcode");
                assert (retire.pc == want.pc) else flag_mismatch("retire.pc", retire.pc, want.pc);
                assert (retire.wr == want.wr)
                    else flag_mismatch("retire.wr", {31'd0, retire.wr}, {31'd0, want.wr});
                if (want.wr) begin
                    assert (retire.rd == want.rd)
                        else flag_mismatch("retire.rd", {27'd0, retire.rd}, {27'd0, want.rd});
                    assert (retire.wdata == want.wdata)
                        else flag_mismatch("retire.wdata", retire.wdata, want.wdata);
                end
                if (want.is_store) begin
                    assert (wr_addr_q.size() > 0)
                        else abort_run("store retired without a write on the memory bus");
                    wa = wr_addr_q.pop_front();
                    wd = wr_data_q.pop_front();
                    assert (wa == want.st_addr[11:2])
                        else flag_mismatch("mem_req.addr", {22'd0, wa},
                                           {22'd0, want.st_addr[11:2]});
                    assert (wd == want.st_data)
                        else flag_mismatch("mem_req.wdata", wd, want.st_data);
                    stores_seen++;
                end
                if (want.is_load)
                    loads_seen++;
                if (want.jumped)
                    jumps_seen++;
                if (want.pc == final_pc)
                    loop_retires++;
            end
        end
    end

    initial begin
        rst_n   = 1'b0;
        mem_rsp = '0;
        req_q   = '0;
        build_program();
        for (int a = 0; a < 1024; a++)
            iss_mem[a] = mem[a];
        for (int i = 0; i < 32; i++)
            iss_regs[i] = '0;
        iss_pc      = reset_pc;
        cycle_limit = 4 * prog_len + 200;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        while (loop_retires < 2)
            @(posedge clk);
        @(posedge clk);
        if (both_req > 0 && loads_seen > 0 && stores_seen > 0 && jumps_seen > 0 &&
            wr_addr_q.size() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("program ended without reaching every check");
        end
    end

endmodule

//--- src.f
+incdir+bench
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/id_ex_regs.sv
hdl/execute_unit.sv
hdl/mem_arbiter.sv
hdl/core_top.sv
bench/core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert --top-module core_tb -f src.f \
    -o core_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status, see build.log"
    exit 1
fi

./obj_dir/core_sim > sim.log 2>&1
run_status=$?
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status, see sim.log"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    echo "PASS"
    exit 0
fi

echo "FAIL, see sim.log"
exit 1
